/* hw/boot_pkg.sv */
// Boot shared definitions
`default_nettype none

package boot_pkg;

	typedef logic [7:0] byte_t;                // one RAM data byte
	typedef logic [7:0] apb_addr_t;            // APB register address
	typedef logic [31:0] apb_data_t;           // APB data word

	// boot phases
	typedef enum logic [1:0] {
		LOAD  = 2'd0,
		CHECK = 2'd1,
		RUN   = 2'd2,
		ERASE = 2'd3
	} boot_state_e;

	// current RAM owner
	typedef enum logic [1:0] {
		GRANT_LOADER  = 2'd0,
		GRANT_ERASER  = 2'd1,
		GRANT_CHECKER = 2'd2,
		GRANT_CPU     = 2'd3
	} grant_e;

	// firmware signature, address 0 in the top byte
	localparam logic [31:0] ROM_SIGNATURE = 32'hF3C35A02;
	localparam int SIGNATURE_LEN = 4;

	localparam int CPU_DIV = 8;                // sys_clock cycles per cpu_ena
	localparam int PSG_DIV = 16;               // sys_clock cycles per psg_ena

	localparam byte_t ERASE_FILL = 8'h00;

	// APB register map
	localparam apb_addr_t LOAD_ADDR_OFS = 8'h00;
	localparam apb_addr_t LOAD_DATA_OFS = 8'h04;
	localparam apb_addr_t CONTROL_OFS   = 8'h08;
	localparam apb_addr_t STATUS_OFS    = 8'h0C;

endpackage

`default_nettype wire

/* hw/mem_port_if.sv */
// Byte RAM request port
`timescale 1ns/100ps
`default_nettype none

interface mem_port_if import boot_pkg::*; #(
	parameter int ADDR_WIDTH = 10
);

	logic [ADDR_WIDTH-1:0] addr;   // byte address
	byte_t                 wdata;  // write byte
	logic                  wr;     // write strobe, one byte per cycle
	logic                  rd;     // read request
	byte_t                 rdata;  // byte at last clock's address

	// side that asks for RAM cycles
	modport requester (output addr, wdata, wr, rd, input rdata);

	// RAM side
	modport ram (input addr, wdata, wr, rd, output rdata);

endinterface

`default_nettype wire

/* hw/clock_enables.sv */
// CPU and sound clock enables
`timescale 1ns/100ps
`default_nettype none

module clock_enables import boot_pkg::*; (
	input  logic sys_clock,
	input  logic RESET,
	output logic cpu_ena,
	output logic psg_ena
);

	localparam int CNT_W = $clog2(PSG_DIV);   // 4 bits for 16
	localparam int CPU_W = $clog2(CPU_DIV);   // low bits that pick the cpu phase

	logic [CNT_W-1:0] cnt_q;

	// free running, wraps at PSG_DIV
	always_ff @(posedge sys_clock) begin
		if (RESET) begin
			cnt_q <= '0;
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// values 0 and 8 for the cpu
	assign cpu_ena = (cnt_q[CPU_W-1:0] == '0);
	// value 0 only, always lands on a cpu_ena
	assign psg_ena = (cnt_q == '0);

endmodule

`default_nettype wire

/* hw/boot_sequencer.sv */
// Boot phase controller
`timescale 1ns/100ps
`default_nettype none

module boot_sequencer import boot_pkg::*; (
	input  logic        sys_clock,
	input  logic        RESET,
	input  logic        load_done,     // loader saw CONTROL bit 0
	input  logic        erase_request, // loader saw CONTROL bit 1
	input  logic        check_done,
	input  logic        erase_done,
	output boot_state_e state,
	output grant_e      grant,
	output logic        check_start,
	output logic        erase_start,
	output logic        cpu_reset,
	output logic        cpu_wait
);

	always_ff @(posedge sys_clock) begin
		if (RESET) begin
			state       <= LOAD;
			check_start <= 1'b0;
			erase_start <= 1'b0;
		end else begin
			check_start <= 1'b0; // start pulses last one cycle
			erase_start <= 1'b0;
			case (state)
				LOAD: if (load_done) begin
					state       <= CHECK;
					check_start <= 1'b1;
				end
				CHECK: if (check_done) begin
					state <= RUN; // runs even on a bad signature
				end
				RUN: if (erase_request) begin
					state       <= ERASE;
					erase_start <= 1'b1;
				end
				ERASE: if (erase_done) begin
					state <= LOAD; // wait for a fresh ROM
				end
				default: state <= LOAD;
			endcase
		end
	end

	// RAM owner follows the phase
	always_comb begin
		case (state)
			LOAD:    grant = GRANT_LOADER;
			CHECK:   grant = GRANT_CHECKER;
			ERASE:   grant = GRANT_ERASER;
			default: grant = GRANT_CPU;
		endcase
	end

	assign cpu_reset = (state == LOAD) || (state == ERASE);
	assign cpu_wait  = (state != RUN); // also stalls the cpu during the check

endmodule

`default_nettype wire

/* hw/rom_loader.sv */
// APB ROM loader
`timescale 1ns/100ps
`default_nettype none

module rom_loader import boot_pkg::*; #(
	parameter int ADDR_WIDTH = 10
) (
	input  logic        sys_clock,
	input  logic        RESET,
	input  apb_addr_t   paddr,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  apb_data_t   pwdata,
	output apb_data_t   prdata,
	output logic        pready,
	output logic        pslverr,
	input  boot_state_e state,
	input  logic        rom_ok,
	output logic        load_done,
	output logic        erase_request,
	mem_port_if.requester port
);

	logic [ADDR_WIDTH-1:0] load_addr_q; // next byte goes here
	logic access;                       // access phase, zero wait states
	logic wr_access;
	logic known_ofs;
	logic data_wr_bad;                  // data write outside LOAD

	assign access      = psel && penable;
	assign wr_access   = access && pwrite;
	assign known_ofs   = (paddr == LOAD_ADDR_OFS) || (paddr == LOAD_DATA_OFS)
		|| (paddr == CONTROL_OFS) || (paddr == STATUS_OFS);
	assign data_wr_bad = (paddr == LOAD_DATA_OFS) && (state != LOAD);

	assign pready  = 1'b1;
	assign pslverr = access && (!known_ofs || (pwrite && data_wr_bad));

	// byte goes to RAM on the clock that ends the access
	assign port.addr  = load_addr_q;
	assign port.wdata = pwdata[7:0];
	assign port.wr    = wr_access && (paddr == LOAD_DATA_OFS) && (state == LOAD);
	assign port.rd    = 1'b0; // write only

	always_ff @(posedge sys_clock) begin
		if (RESET) begin
			load_addr_q   <= '0;
			load_done     <= 1'b0;
			erase_request <= 1'b0;
		end else begin
			load_done     <= wr_access && (paddr == CONTROL_OFS) && pwdata[0] && (state == LOAD);
			erase_request <= wr_access && (paddr == CONTROL_OFS) && pwdata[1] && (state == RUN);
			if (wr_access && (paddr == LOAD_ADDR_OFS)) begin
				load_addr_q <= pwdata[ADDR_WIDTH-1:0];
			end else if (port.wr) begin
				load_addr_q <= load_addr_q + 1'b1; // auto increment
			end
		end
	end

	// read mux, unmapped reads give zero
	always_comb begin
		prdata = '0;
		if (paddr == STATUS_OFS) begin
			prdata[0] = (state != LOAD);   // loaded
			prdata[1] = (state == ERASE);  // erasing
			prdata[2] = rom_ok;
			prdata[3] = (state == RUN);    // cpu running
		end else if (paddr == LOAD_ADDR_OFS) begin
			prdata[ADDR_WIDTH-1:0] = load_addr_q;
		end
	end

endmodule

`default_nettype wire

/* hw/memory_eraser.sv */
// RAM eraser
`timescale 1ns/100ps
`default_nettype none

module memory_eraser import boot_pkg::*; #(
	parameter int ADDR_WIDTH = 10
) (
	input  logic sys_clock,
	input  logic RESET,
	input  logic cpu_ena,
	input  logic erase_start,
	output logic erase_done,
	mem_port_if.requester port
);

	logic                  busy_q;
	logic [ADDR_WIDTH-1:0] addr_q;  // address being cleared

	// one byte per cpu_ena
	assign port.addr  = addr_q;
	assign port.wdata = ERASE_FILL;
	assign port.wr    = busy_q && cpu_ena;
	assign port.rd    = 1'b0;

	always_ff @(posedge sys_clock) begin
		if (RESET) begin
			busy_q     <= 1'b0;
			addr_q     <= '0;
			erase_done <= 1'b0;
		end else begin
			erase_done <= 1'b0;
			if (erase_start) begin
				busy_q <= 1'b1;
				addr_q <= '0;
			end else if (busy_q && cpu_ena) begin
				if (&addr_q) begin // top address written
					busy_q     <= 1'b0;
					erase_done <= 1'b1;
				end else begin
					addr_q <= addr_q + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/rom_checker.sv */
// ROM signature checker
`timescale 1ns/100ps
`default_nettype none

module rom_checker import boot_pkg::*; (
	input  logic sys_clock,
	input  logic RESET,
	input  logic cpu_ena,
	input  logic check_start,
	output logic check_done,
	output logic rom_ok,
	mem_port_if.requester port
);

	localparam int IDX_W = $clog2(SIGNATURE_LEN);
	localparam int HIT_W = $clog2(SIGNATURE_LEN + 1);

	logic             busy_q;
	logic             issued_q;  // address already on the port for one cpu_ena
	logic [IDX_W-1:0] idx_q;     // signature byte being read
	logic [HIT_W-1:0] hits_q;    // matching bytes so far
	byte_t            expected;
	logic             hit;

	// byte 0 sits in the top of the constant
	assign expected = ROM_SIGNATURE[8 * (SIGNATURE_LEN - 1 - int'(idx_q)) +: 8];
	assign hit      = (port.rdata == expected);

	always_comb begin
		port.addr              = '0;
		port.addr[IDX_W-1:0]   = idx_q;
		port.wdata             = '0;
		port.wr                = 1'b0;   // never writes
		port.rd                = busy_q;
	end

	always_ff @(posedge sys_clock) begin
		if (RESET) begin
			busy_q     <= 1'b0;
			issued_q   <= 1'b0;
			idx_q      <= '0;
			hits_q     <= '0;
			check_done <= 1'b0;
			rom_ok     <= 1'b0;
		end else begin
			check_done <= 1'b0;
			if (check_start) begin
				busy_q   <= 1'b1;
				issued_q <= 1'b0;
				idx_q    <= '0;
				hits_q   <= '0;
				rom_ok   <= 1'b0;  // stale result gone
			end else if (busy_q && cpu_ena) begin
				issued_q <= 1'b1;
				if (issued_q) begin
					// rdata is stable here, address held since last cpu_ena
					if (idx_q == IDX_W'(SIGNATURE_LEN - 1)) begin
						busy_q     <= 1'b0;
						check_done <= 1'b1;
						rom_ok     <= (hits_q + HIT_W'(hit)) == HIT_W'(SIGNATURE_LEN);
					end else begin
						hits_q <= hits_q + HIT_W'(hit);
						idx_q  <= idx_q + 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hw/system_ram.sv */
// Shared byte RAM with owner mux
`timescale 1ns/100ps
`default_nettype none

module system_ram import boot_pkg::*; #(
	parameter int ADDR_WIDTH = 10
) (
	input  logic   sys_clock,
	input  grant_e grant,
	mem_port_if.ram loader_port,
	mem_port_if.ram eraser_port,
	mem_port_if.ram checker_port,
	mem_port_if.ram cpu_port
);

	byte_t mem [2**ADDR_WIDTH];

	logic [ADDR_WIDTH-1:0] sel_addr;
	byte_t                 sel_wdata;
	logic                  sel_wr;
	logic                  sel_rd;
	byte_t                 rdata_q;

	// only the owner reaches the array
	always_comb begin
		case (grant)
			GRANT_LOADER: begin
				sel_addr  = loader_port.addr;
				sel_wdata = loader_port.wdata;
				sel_wr    = loader_port.wr;
				sel_rd    = loader_port.rd;
			end
			GRANT_ERASER: begin
				sel_addr  = eraser_port.addr;
				sel_wdata = eraser_port.wdata;
				sel_wr    = eraser_port.wr;
				sel_rd    = eraser_port.rd;
			end
			GRANT_CHECKER: begin
				sel_addr  = checker_port.addr;
				sel_wdata = checker_port.wdata;
				sel_wr    = checker_port.wr;
				sel_rd    = checker_port.rd;
			end
			default: begin
				sel_addr  = cpu_port.addr;
				sel_wdata = cpu_port.wdata;
				sel_wr    = cpu_port.wr;
				sel_rd    = cpu_port.rd;
			end
		endcase
	end

	always_ff @(posedge sys_clock) begin
		if (sel_wr) begin
			mem[sel_addr] <= sel_wdata;
		end
		if (sel_rd) begin
			rdata_q <= mem[sel_addr]; // old data on read during write
		end
	end

	// every port sees the array output
	assign loader_port.rdata  = rdata_q;
	assign eraser_port.rdata  = rdata_q;
	assign checker_port.rdata = rdata_q;
	assign cpu_port.rdata     = rdata_q;

endmodule

`default_nettype wire

/* hw/lm80c_boot.sv */
// LM80C boot top level
`timescale 1ns/100ps
`default_nettype none

module lm80c_boot import boot_pkg::*; #(
	parameter int ADDR_WIDTH = 10
) (
	input  logic                  sys_clock,
	input  logic                  RESET,
	input  apb_addr_t             paddr,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  apb_data_t             pwdata,
	output apb_data_t             prdata,
	output logic                  pready,
	output logic                  pslverr,
	input  logic [ADDR_WIDTH-1:0] cpu_addr,
	input  byte_t                 cpu_wdata,
	input  logic                  cpu_wr,
	input  logic                  cpu_rd,
	output byte_t                 cpu_rdata,
	output logic                  cpu_reset,
	output logic                  cpu_wait,
	output logic                  cpu_ena,
	output logic                  psg_ena,
	output logic                  led
);

	boot_state_e state;
	grant_e      grant;
	logic load_done, erase_request, check_start, check_done;
	logic erase_start, erase_done, rom_ok;

	mem_port_if #(.ADDR_WIDTH(ADDR_WIDTH)) loader_port ();
	mem_port_if #(.ADDR_WIDTH(ADDR_WIDTH)) eraser_port ();
	mem_port_if #(.ADDR_WIDTH(ADDR_WIDTH)) checker_port ();
	mem_port_if #(.ADDR_WIDTH(ADDR_WIDTH)) cpu_port ();

	// cpu side of the RAM
	assign cpu_port.addr  = cpu_addr;
	assign cpu_port.wdata = cpu_wdata;
	assign cpu_port.wr    = cpu_wr;
	assign cpu_port.rd    = cpu_rd;
	assign cpu_rdata      = cpu_port.rdata;

	assign led = rom_ok; // lit on a good signature

	clock_enables clock_enables_inst (.sys_clock, .RESET, .cpu_ena, .psg_ena);

	boot_sequencer boot_sequencer_inst (
		.sys_clock, .RESET, .load_done, .erase_request, .check_done, .erase_done,
		.state, .grant, .check_start, .erase_start, .cpu_reset, .cpu_wait
	);

	rom_loader #(.ADDR_WIDTH(ADDR_WIDTH)) rom_loader_inst (
		.sys_clock, .RESET, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
		.pready, .pslverr, .state, .rom_ok, .load_done, .erase_request,
		.port(loader_port)
	);

	memory_eraser #(.ADDR_WIDTH(ADDR_WIDTH)) memory_eraser_inst (
		.sys_clock, .RESET, .cpu_ena, .erase_start, .erase_done, .port(eraser_port)
	);

	rom_checker rom_checker_inst (
		.sys_clock, .RESET, .cpu_ena, .check_start, .check_done, .rom_ok,
		.port(checker_port)
	);

	system_ram #(.ADDR_WIDTH(ADDR_WIDTH)) system_ram_inst (
		.sys_clock, .grant, .loader_port, .eraser_port, .checker_port, .cpu_port
	);

endmodule

`default_nettype wire

/* sim/lm80c_boot_assertions.sv */
// Boot sequencer checks
`timescale 1ns/100ps
`default_nettype none

module lm80c_boot_assertions import boot_pkg::*; (
	input logic        sys_clock,
	input logic        RESET,
	input boot_state_e state,
	input grant_e      grant,
	input logic        check_start,
	input logic        erase_start,
	input logic        cpu_reset,
	input logic        cpu_wait
);

	int error_count = 0;  // failed assertions so far

	// cpu fully released only in RUN, reached through CHECK
	cpu_free_in_run: assert property (@(posedge sys_clock) disable iff (RESET)
		(!cpu_reset && !cpu_wait) |->
			(state == RUN && ($past(state) == CHECK || $past(state) == RUN)))
	else begin
		error_count++;
		$error("cpu released outside RUN");
	end

	check_start_pulse: assert property (@(posedge sys_clock) disable iff (RESET)
		check_start |=> !check_start)
	else begin
		error_count++;
		$error("check_start longer than one cycle");
	end

	erase_start_pulse: assert property (@(posedge sys_clock) disable iff (RESET)
		erase_start |=> !erase_start)
	else begin
		error_count++;
		$error("erase_start longer than one cycle");
	end

	// started requester owns the RAM in its own phase
	grant_follows_state: assert property (@(posedge sys_clock) disable iff (RESET)
		(check_start || erase_start) |->
			(check_start ? (state == CHECK && grant == GRANT_CHECKER)
				: (state == ERASE && grant == GRANT_ERASER)))
	else begin
		error_count++;
		$error("grant does not match state");
	end

endmodule

bind boot_sequencer lm80c_boot_assertions seq_checks (
	.sys_clock(sys_clock),
	.RESET(RESET),
	.state(state),
	.grant(grant),
	.check_start(check_start),
	.erase_start(erase_start),
	.cpu_reset(cpu_reset),
	.cpu_wait(cpu_wait)
);

`default_nettype wire

/* sim/tb_lm80c_boot.sv */
// LM80C boot testbench
`timescale 1ns/100ps
`default_nettype none

module tb_lm80c_boot import boot_pkg::*; ();

	localparam int ADDR_WIDTH  = 10;
	localparam int RAM_DEPTH   = 1 << ADDR_WIDTH;
	localparam int HALF_PERIOD = 50;     // 100 ns clock
	localparam int CPU_PERIOD  = 8;
	localparam int PSG_PERIOD  = 16;
	localparam int EXTRA_BYTES = 12;     // random bytes after the signature
	localparam int MAX_CYCLES  = 40000;  // two full erases are about 16k cycles

	logic sys_clock;
	logic RESET;
	apb_addr_t paddr;
	logic psel, penable, pwrite;
	apb_data_t pwdata, prdata;
	logic pready, pslverr;
	logic [ADDR_WIDTH-1:0] cpu_addr;
	byte_t cpu_wdata, cpu_rdata;
	logic cpu_wr, cpu_rd, cpu_reset, cpu_wait, cpu_ena, psg_ena, led;

	byte_t       model [RAM_DEPTH];  // expected RAM contents
	boot_state_e exp_phase;
	logic        exp_ok;
	integer      seed;
	int          cycles = 0;
	int          cpu_gap, psg_gap;
	logic        cpu_seen, psg_seen;
	logic [31:0] got_q [$];          // pending compares
	logic [31:0] exp_q [$];
	string       what_q [$];

	lm80c_boot #(.ADDR_WIDTH(ADDR_WIDTH)) lm80c_boot_inst (
		.sys_clock, .RESET, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
		.pready, .pslverr, .cpu_addr, .cpu_wdata, .cpu_wr, .cpu_rd, .cpu_rdata,
		.cpu_reset, .cpu_wait, .cpu_ena, .psg_ena, .led
	);

	initial begin
		sys_clock = 1'b0;
		forever #HALF_PERIOD sys_clock = ~sys_clock;
	end

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("FAIL %0t: %s, got %0h expected %0h", $time, what, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// signature bytes F3 C3 5A 02 at addresses 0..3
	function automatic logic expected_rom_ok();
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < 4; i++) begin
			if (model[i] !== ROM_SIGNATURE[31 - 8 * i -: 8]) ok = 1'b0;
		end
		return ok;
	endfunction

	function automatic logic [31:0] expected_status(input boot_state_e ph, input logic ok);
		logic [31:0] s;
		s    = '0;
		s[0] = (ph != LOAD);   // loaded
		s[1] = (ph == ERASE);
		s[2] = ok;
		s[3] = (ph == RUN);
		return s;
	endfunction

	task automatic expect_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		got_q.push_back(got);
		exp_q.push_back(exp);
		what_q.push_back(what);
	endtask

	// called on a falling edge, returns on a falling edge
	task automatic apb_transfer(input apb_addr_t addr, input logic write, input apb_data_t wdata,
			output apb_data_t rdata, output logic err);
		paddr   = addr;
		pwrite  = write;
		pwdata  = wdata;
		psel    = 1'b1;  // setup phase
		penable = 1'b0;
		@(negedge sys_clock);
		penable = 1'b1;
		#(HALF_PERIOD / 2);  // mid low phase
		rdata = prdata;
		err   = pslverr;
		check_equal(pready, 1'b1, "pready low");
		@(negedge sys_clock);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
		apb_data_t rdata;
		logic      err;
		apb_transfer(addr, 1'b1, data, rdata, err);
		check_equal(err, exp_err, $sformatf("pslverr on write to %0h", addr));
	endtask

	task automatic read_status(output apb_data_t status);
		logic err;
		apb_transfer(STATUS_OFS, 1'b0, '0, status, err);
		check_equal(err, 1'b0, "pslverr on STATUS read");
	endtask

	task automatic wait_status(input apb_data_t mask, input apb_data_t value);
		apb_data_t status;
		read_status(status);
		while ((status & mask) != value) read_status(status); // timeout bounds this
	endtask

	task automatic load_model(input int count);
		apb_write(LOAD_ADDR_OFS, 32'h0, 1'b0);
		for (int i = 0; i < count; i++) begin
			apb_write(LOAD_DATA_OFS, {24'h0, model[i]}, 1'b0);
		end
	endtask

	task automatic cpu_read(input int addr);
		cpu_addr = addr[ADDR_WIDTH-1:0];
		cpu_rd   = 1'b1;
		@(negedge sys_clock);  // rdata registered one cycle later
		cpu_rd = 1'b0;
		expect_value(cpu_rdata, model[addr], $sformatf("cpu read at %0d", addr));
	endtask

	task automatic cpu_write(input int addr, input byte_t data);
		cpu_addr  = addr[ADDR_WIDTH-1:0];
		cpu_wdata = data;
		cpu_wr    = 1'b1;
		@(negedge sys_clock);
		cpu_wr      = 1'b0;
		model[addr] = data;
	endtask

	// request done, check done, wait for ROM
	task automatic start_and_run();
		apb_data_t status;
		apb_write(CONTROL_OFS, 32'h1, 1'b0);
		exp_ok = expected_rom_ok();
		wait_status(32'h8, 32'h8);
		exp_phase = RUN;
		read_status(status);
		expect_value(status, expected_status(exp_phase, exp_ok), "STATUS in RUN");
		check_equal(led, exp_ok, "led after check");
		check_equal(cpu_reset, 1'b0, "cpu_reset in RUN");
		check_equal(cpu_wait, 1'b0, "cpu_wait in RUN");
	endtask

	task automatic erase_ram();
		apb_data_t status;
		apb_write(CONTROL_OFS, 32'h2, 1'b0);
		wait_status(32'h2, 32'h2);
		exp_phase = ERASE;
		check_equal(cpu_reset, 1'b1, "cpu_reset during erase");
		read_status(status);
		expect_value(status, expected_status(exp_phase, exp_ok), "STATUS during erase");
		apb_write(LOAD_DATA_OFS, 32'hAA, 1'b1);  // not in LOAD
		wait_status(32'h1, 32'h0);               // back to LOAD
		exp_phase = LOAD;
		for (int i = 0; i < RAM_DEPTH; i++) model[i] = 8'h00;
		read_status(status);
		expect_value(status, expected_status(exp_phase, exp_ok), "STATUS after erase");
		check_equal(cpu_reset, 1'b1, "cpu_reset in LOAD");
	endtask

	// enable spacing, watched for the whole run
	always @(negedge sys_clock) begin
		if (RESET) begin
			cpu_gap  = 0;
			psg_gap  = 0;
			cpu_seen = 1'b0;
			psg_seen = 1'b0;
		end else begin
			cpu_gap = cpu_gap + 1;
			psg_gap = psg_gap + 1;
			if (psg_ena) check_equal(cpu_ena, 1'b1, "psg_ena without cpu_ena");
			if (cpu_ena || (cpu_seen && cpu_gap > CPU_PERIOD)) begin
				if (cpu_seen) check_equal(cpu_gap, CPU_PERIOD, "cpu_ena spacing");
				cpu_seen = 1'b1;
				cpu_gap  = 0;
			end
			if (psg_ena || (psg_seen && psg_gap > PSG_PERIOD)) begin
				if (psg_seen) check_equal(psg_gap, PSG_PERIOD, "psg_ena spacing");
				psg_seen = 1'b1;
				psg_gap  = 0;
			end
		end
	end

	// compare process
	always @(negedge sys_clock) begin
		while (got_q.size() > 0) begin
			check_equal(got_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
		end
	end

	always @(posedge sys_clock) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("SOME TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	initial begin
		apb_data_t status;
		apb_data_t rdata;
		logic      err;
		logic      all_ok;
		seed      = 32'h94eaf64c;
		RESET     = 1'b1;
		paddr     = '0;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		pwdata    = '0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		cpu_wr    = 1'b0;
		cpu_rd    = 1'b0;
		exp_phase = LOAD;
		exp_ok    = 1'b0;
		repeat (2) @(negedge sys_clock);
		RESET = 1'b0;

		check_equal(cpu_reset, 1'b1, "cpu_reset after reset");
		check_equal(cpu_wait, 1'b1, "cpu_wait after reset");
		check_equal(led, 1'b0, "led after reset");
		read_status(status);
		expect_value(status, expected_status(exp_phase, exp_ok), "STATUS after reset");
		apb_transfer(8'h10, 1'b1, 32'h5, rdata, err);  // unmapped
		check_equal(err, 1'b1, "pslverr on unknown write");
		apb_transfer(8'h14, 1'b0, '0, rdata, err);
		check_equal(err, 1'b1, "pslverr on unknown read");
		repeat (2 * PSG_PERIOD) @(negedge sys_clock);  // enables only

		// good ROM
		for (int i = 0; i < 4; i++) model[i] = ROM_SIGNATURE[31 - 8 * i -: 8];
		for (int i = 4; i < 4 + EXTRA_BYTES; i++) model[i] = byte_t'($random(seed));
		load_model(4 + EXTRA_BYTES);
		start_and_run();
		check_equal(led, 1'b1, "led on good ROM");

		// cpu reads then writes
		for (int i = 0; i < 4 + EXTRA_BYTES; i++) cpu_read(i);
		for (int i = 0; i < 8; i++) cpu_write(100 + 3 * i, byte_t'($random(seed)));
		for (int i = 0; i < 8; i++) cpu_read(100 + 3 * i);
		apb_write(LOAD_DATA_OFS, 32'h55, 1'b1);
		erase_ram();

		// bad ROM, one corrupted signature byte
		for (int i = 0; i < 4; i++) model[i] = ROM_SIGNATURE[31 - 8 * i -: 8];
		model[2] = model[2] ^ (byte_t'($random(seed)) | 8'h01);
		load_model(4);
		start_and_run();
		check_equal(led, 1'b0, "led on bad ROM");
		for (int i = 0; i < 20; i++) cpu_read(i);
		for (int i = 0; i < 8; i++) cpu_read(100 + 3 * i);  // erased earlier
		erase_ram();

		repeat (2) @(negedge sys_clock);  // let the compare queue drain
		all_ok = (got_q.size() == 0)
			&& (lm80c_boot_inst.boot_sequencer_inst.seq_checks.error_count == 0);
		if (all_ok) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("sequencer assertions failed or compares were left over");
			$display("SOME TESTS FAILED");
			$fatal(1, "run failed");
		end
	end

endmodule

`default_nettype wire

/* project.f */
hw/boot_pkg.sv
hw/mem_port_if.sv
hw/clock_enables.sv
hw/boot_sequencer.sv
hw/rom_loader.sv
hw/memory_eraser.sv
hw/rom_checker.sv
hw/system_ram.sv
hw/lm80c_boot.sv
sim/lm80c_boot_assertions.sv
sim/tb_lm80c_boot.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lm80c_boot
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= ALL TESTS PASSED

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
